// ==== design/core_cfg.svh ====
// Core configuration macros for widths, register counts, report range and queue depth
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Registers whose writes are sent out as report messages
`define RPT_REG_LO 10
`define RPT_REG_HI 17

// Report FIFO entries
`define RPT_DEPTH 4

// Stages that may still push a report after the stall is raised:
// execute input register and writeback register
`define PIPE_SLOTS 2

`endif

// ==== design/isa_pkg.sv ====
// Instruction word views, opcode values and funct3/funct7 codes
package isa_pkg;

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_form_t;

  // Register-immediate layout; upper 20 bits double as the LUI immediate
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_form_t;

  // One instruction word, decoded either way
  typedef union packed {
    r_form_t r;
    i_form_t i;
  } inst_word_u;

  // Supported major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 bit picking SUB over ADD and SRA over SRL (instruction bit 30)
  localparam int F7_ALT_BIT = 5;

endpackage

// ==== design/alu_pkg.sv ====
// ALU operation codes and operand-B select codes
package alu_pkg;

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_PASSB = 4'd9;

  // Operand B source
  localparam logic SRC_B_REG = 1'b0;
  localparam logic SRC_B_IMM = 1'b1;

endpackage

// ==== design/inst_intake.sv ====
// Two-entry instruction skid buffer with a registered ready
`timescale 1ns/100ps
`include "core_cfg.svh"

module inst_intake (
  input  logic             clock,
  input  logic             i_rst_n,
  input  logic             i_inst_valid,
  input  logic [`XLEN-1:0] i_inst,
  output logic             o_inst_ready,
  output logic             o_dec_valid,
  output logic [`XLEN-1:0] o_dec_inst,
  input  logic             i_advance
);

  logic [`XLEN-1:0] slot [0:1];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       count;
  logic [1:0]       count_next;
  logic             push;
  logic             pop;

  assign push = i_inst_valid & o_inst_ready;
  assign pop  = o_dec_valid & i_advance;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 2'd1;
    end else if (pop && !push) begin
      count_next = count - 2'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      wr_ptr       <= 1'b0;
      rd_ptr       <= 1'b0;
      count        <= 2'd0;
      o_inst_ready <= 1'b0;
    end else begin
      count <= count_next;
      // Offer a slot next cycle only if one is still free after this edge
      o_inst_ready <= (count_next != 2'd2);
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      slot[wr_ptr] <= i_inst;
    end
  end

  assign o_dec_valid = (count != 2'd0);
  assign o_dec_inst  = slot[rd_ptr];

  // Source must hold a refused word until it is taken
  a_inst_hold: assert property (@(posedge clock) disable iff (!i_rst_n)
    (i_inst_valid && !o_inst_ready) |=> (i_inst_valid && $stable(i_inst)))
    else $error("instruction changed while waiting for ready");

endmodule

// ==== design/decode_regread.sv ====
// Instruction decode, register file, operand bypass and execute-stage register
`timescale 1ns/100ps
`include "core_cfg.svh"

module decode_regread import isa_pkg::*, alu_pkg::*; (
  input  logic                   clock,
  input  logic                   i_rst_n,
  input  logic                   i_dec_valid,
  input  logic [`XLEN-1:0]       i_dec_inst,
  input  logic                   i_room,
  output logic                   o_advance,
  input  logic [`XLEN-1:0]       i_ex_result,
  input  logic                   i_wb_valid,
  input  logic                   i_wb_wr,
  input  logic [`REG_ADDR_W-1:0] i_wb_rd,
  input  logic [`XLEN-1:0]       i_wb_data,
  output logic                   o_ex_valid,
  output logic                   o_ex_wr,
  output logic [`REG_ADDR_W-1:0] o_ex_rd,
  output logic [ALU_OP_W-1:0]    o_ex_alu_op,
  output logic [`XLEN-1:0]       o_ex_a,
  output logic [`XLEN-1:0]       o_ex_b
);

  inst_word_u          inst;
  logic                alt;
  logic                known_f3;
  logic                op_supported;
  logic                rd_write;
  logic [ALU_OP_W-1:0] alu_op;
  logic                src_b_sel;
  logic [`XLEN-1:0]    imm_value;
  logic [`XLEN-1:0]    regs [0:`REG_COUNT-1];
  logic                rf_we;
  logic [`XLEN-1:0]    rs1_value;
  logic [`XLEN-1:0]    rs2_value;

  assign inst = i_dec_inst;

  // Report back-pressure is the only stall source
  assign o_advance = i_room;

  always_comb begin
    alt          = inst.r.funct7[F7_ALT_BIT];
    known_f3     = 1'b1;
    op_supported = 1'b0;
    alu_op       = ALU_ADD;
    src_b_sel    = SRC_B_REG;
    imm_value    = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};

    case (inst.r.funct3)
      // ADDI has no subtract form, its bit 30 is immediate
      F3_ADD_SUB: alu_op = (inst.r.opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op = ALU_SLL;
      F3_SLT:     alu_op = ALU_SLT;
      F3_XOR:     alu_op = ALU_XOR;
      F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op = ALU_OR;
      F3_AND:     alu_op = ALU_AND;
      default:    known_f3 = 1'b0;
    endcase

    case (inst.r.opcode)
      OPC_OP: begin
        op_supported = known_f3;
      end
      OPC_OP_IMM: begin
        op_supported = known_f3;
        src_b_sel    = SRC_B_IMM;
      end
      OPC_LUI: begin
        op_supported = 1'b1;
        src_b_sel    = SRC_B_IMM;
        alu_op       = ALU_PASSB;
        imm_value    = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'd0};
      end
      default: begin
        op_supported = 1'b0;
      end
    endcase
  end

  // x0 is never a destination
  assign rd_write = op_supported && (inst.r.rd != '0);

  // Youngest in-flight writer wins, then writeback, then the file
  function automatic logic [`XLEN-1:0] read_operand(input logic [`REG_ADDR_W-1:0] rs);
    if (o_ex_wr && (o_ex_rd == rs)) begin
      return i_ex_result;
    end else if (i_wb_wr && (i_wb_rd == rs)) begin
      return i_wb_data;
    end
    return regs[rs];
  endfunction

  always_comb begin
    rs1_value = read_operand(inst.r.rs1);
    rs2_value = read_operand(inst.r.rs2);
  end

  // Retire in step with the report push
  assign rf_we = o_advance & i_wb_valid & i_wb_wr;

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      for (int idx = 0; idx < `REG_COUNT; idx++) begin
        regs[idx] <= '0;
      end
    end else if (rf_we) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_ex_valid <= 1'b0;
      o_ex_wr    <= 1'b0;
    end else if (o_advance) begin
      o_ex_valid <= i_dec_valid;
      o_ex_wr    <= i_dec_valid & rd_write;
    end
  end

  always_ff @(posedge clock) begin
    if (o_advance) begin
      o_ex_rd     <= inst.r.rd;
      o_ex_alu_op <= alu_op;
      o_ex_a      <= rs1_value;
      o_ex_b      <= (src_b_sel == SRC_B_IMM) ? imm_value : rs2_value;
    end
  end

  // Write enable travels through execute and writeback before landing here
  a_no_x0_write: assert property (@(posedge clock) disable iff (!i_rst_n)
    rf_we |-> (i_wb_rd != '0))
    else $error("register file write to x0");

endmodule

// ==== design/alu_execute.sv ====
// Integer ALU and writeback-stage register
`timescale 1ns/100ps
`include "core_cfg.svh"

module alu_execute import alu_pkg::*; (
  input  logic                   clock,
  input  logic                   i_rst_n,
  input  logic                   i_advance,
  input  logic                   i_ex_valid,
  input  logic                   i_ex_wr,
  input  logic [`REG_ADDR_W-1:0] i_ex_rd,
  input  logic [ALU_OP_W-1:0]    i_ex_alu_op,
  input  logic [`XLEN-1:0]       i_ex_a,
  input  logic [`XLEN-1:0]       i_ex_b,
  output logic [`XLEN-1:0]       o_ex_result,
  output logic                   o_wb_valid,
  output logic                   o_wb_wr,
  output logic [`REG_ADDR_W-1:0] o_wb_rd,
  output logic [`XLEN-1:0]       o_wb_data
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]   result;

  assign shamt = i_ex_b[SHAMT_W-1:0];

  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD:   result = i_ex_a + i_ex_b;
      ALU_SUB:   result = i_ex_a - i_ex_b;
      // Signed compare
      ALU_SLT:   result = {{(`XLEN-1){1'b0}}, $signed(i_ex_a) < $signed(i_ex_b)};
      ALU_XOR:   result = i_ex_a ^ i_ex_b;
      ALU_OR:    result = i_ex_a | i_ex_b;
      ALU_AND:   result = i_ex_a & i_ex_b;
      ALU_SLL:   result = i_ex_a << shamt;
      ALU_SRL:   result = i_ex_a >> shamt;
      ALU_SRA:   result = $signed(i_ex_a) >>> shamt;
      ALU_PASSB: result = i_ex_b;
      default:   result = '0;
    endcase
  end

  // Forwarded to decode for back-to-back dependencies
  assign o_ex_result = result;

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_wb_wr    <= 1'b0;
    end else if (i_advance) begin
      o_wb_valid <= i_ex_valid;
      o_wb_wr    <= i_ex_valid & i_ex_wr;
    end
  end

  always_ff @(posedge clock) begin
    if (i_advance) begin
      o_wb_rd   <= i_ex_rd;
      o_wb_data <= result;
    end
  end

endmodule

// ==== design/report_queue.sv ====
// Report FIFO for writes to x10..x17, with room flag and report handshake
`timescale 1ns/100ps
`include "core_cfg.svh"

module report_queue (
  input  logic                   clock,
  input  logic                   i_rst_n,
  input  logic                   i_advance,
  input  logic                   i_wb_valid,
  input  logic                   i_wb_wr,
  input  logic [`REG_ADDR_W-1:0] i_wb_rd,
  input  logic [`XLEN-1:0]       i_wb_data,
  output logic                   o_room,
  output logic                   o_rpt_valid,
  output logic [`REG_ADDR_W-1:0] o_rpt_reg,
  output logic [`XLEN-1:0]       o_rpt_data,
  input  logic                   i_rpt_ready
);

  localparam int PTR_W = $clog2(`RPT_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int RD_W  = `REG_ADDR_W;
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`RPT_DEPTH);
  // Highest count that still leaves space for every in-flight write
  localparam logic [CNT_W-1:0] ROOM_LIMIT = CNT_W'(`RPT_DEPTH - `PIPE_SLOTS - 1);
  localparam logic [RD_W-1:0]  RPT_LO     = RD_W'(`RPT_REG_LO);
  localparam logic [RD_W-1:0]  RPT_HI     = RD_W'(`RPT_REG_HI);

  logic [RD_W-1:0]  reg_mem  [0:`RPT_DEPTH-1];
  logic [`XLEN-1:0] data_mem [0:`RPT_DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             in_range;
  logic             push;
  logic             pop;

  assign in_range = (i_wb_rd >= RPT_LO) && (i_wb_rd <= RPT_HI);
  assign push     = i_advance & i_wb_valid & i_wb_wr & in_range;
  assign pop      = o_rpt_valid & i_rpt_ready;

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      reg_mem[wr_ptr]  <= i_wb_rd;
      data_mem[wr_ptr] <= i_wb_data;
    end
  end

  assign o_room      = (count <= ROOM_LIMIT);
  assign o_rpt_valid = (count != '0);
  assign o_rpt_reg   = reg_mem[rd_ptr];
  assign o_rpt_data  = data_mem[rd_ptr];

  // Stall must be raised early enough that the pipeline never overfills the queue
  a_no_push_full: assert property (@(posedge clock) disable iff (!i_rst_n)
    push |-> (count != FULL_COUNT))
    else $error("report push while FIFO full");

  a_rpt_hold: assert property (@(posedge clock) disable iff (!i_rst_n)
    (o_rpt_valid && !i_rpt_ready) |=>
      (o_rpt_valid && $stable(o_rpt_reg) && $stable(o_rpt_data)))
    else $error("report message changed while waiting for ready");

endmodule

// ==== design/core_top.sv ====
// Core top level connecting intake, decode, execute and report queue
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_top import alu_pkg::*; (
  input  logic                   clock,
  input  logic                   i_rst_n,
  input  logic                   i_inst_valid,
  input  logic [`XLEN-1:0]       i_inst,
  output logic                   o_inst_ready,
  output logic                   o_rpt_valid,
  output logic [`REG_ADDR_W-1:0] o_rpt_reg,
  output logic [`XLEN-1:0]       o_rpt_data,
  input  logic                   i_rpt_ready
);

  // Intake to decode
  logic                   dec_valid;
  logic [`XLEN-1:0]       dec_inst;

  // Stage enable and report room
  logic                   advance;
  logic                   room;

  // Execute stage
  logic                   ex_valid;
  logic                   ex_wr;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic [ALU_OP_W-1:0]    ex_alu_op;
  logic [`XLEN-1:0]       ex_a;
  logic [`XLEN-1:0]       ex_b;
  logic [`XLEN-1:0]       ex_result;

  // Writeback stage
  logic                   wb_valid;
  logic                   wb_wr;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  inst_intake intake_i (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst_ready (o_inst_ready),
    .o_dec_valid  (dec_valid),
    .o_dec_inst   (dec_inst),
    .i_advance    (advance)
  );

  decode_regread decode_i (
    .clock       (clock),
    .i_rst_n     (i_rst_n),
    .i_dec_valid (dec_valid),
    .i_dec_inst  (dec_inst),
    .i_room      (room),
    .o_advance   (advance),
    .i_ex_result (ex_result),
    .i_wb_valid  (wb_valid),
    .i_wb_wr     (wb_wr),
    .i_wb_rd     (wb_rd),
    .i_wb_data   (wb_data),
    .o_ex_valid  (ex_valid),
    .o_ex_wr     (ex_wr),
    .o_ex_rd     (ex_rd),
    .o_ex_alu_op (ex_alu_op),
    .o_ex_a      (ex_a),
    .o_ex_b      (ex_b)
  );

  alu_execute execute_i (
    .clock       (clock),
    .i_rst_n     (i_rst_n),
    .i_advance   (advance),
    .i_ex_valid  (ex_valid),
    .i_ex_wr     (ex_wr),
    .i_ex_rd     (ex_rd),
    .i_ex_alu_op (ex_alu_op),
    .i_ex_a      (ex_a),
    .i_ex_b      (ex_b),
    .o_ex_result (ex_result),
    .o_wb_valid  (wb_valid),
    .o_wb_wr     (wb_wr),
    .o_wb_rd     (wb_rd),
    .o_wb_data   (wb_data)
  );

  report_queue report_i (
    .clock       (clock),
    .i_rst_n     (i_rst_n),
    .i_advance   (advance),
    .i_wb_valid  (wb_valid),
    .i_wb_wr     (wb_wr),
    .i_wb_rd     (wb_rd),
    .i_wb_data   (wb_data),
    .o_room      (room),
    .o_rpt_valid (o_rpt_valid),
    .o_rpt_reg   (o_rpt_reg),
    .o_rpt_data  (o_rpt_data),
    .i_rpt_ready (i_rpt_ready)
  );

endmodule

// ==== testbench/tb_clock.sv ====
// Testbench clock and reset generator
`timescale 1ns/100ps

module tb_clock (
  output logic clock,
  output logic o_rst_n
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 4;

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  // Release lands just after an edge, like the other stimulus
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    o_rst_n = 1'b1;
  end

endmodule

// ==== testbench/tb_top.sv ====
// Testbench top with random instruction stimulus, reference model and report scoreboard
`timescale 1ns/100ps
`include "core_cfg.svh"

module tb_top import isa_pkg::*; ();

  localparam int N_RANDOM     = 600;
  localparam int DRAIN_CYCLES = 20;
  localparam int ENTRY_W      = `REG_ADDR_W + `XLEN;
  localparam logic [6:0] ALT7 = 7'b0100000;

  logic                   clock;
  logic                   rst_n;
  logic                   inst_valid;
  logic [`XLEN-1:0]       inst_word;
  logic                   inst_ready;
  logic                   rpt_valid;
  logic [`REG_ADDR_W-1:0] rpt_reg;
  logic [`XLEN-1:0]       rpt_data;
  logic                   rpt_ready;

  integer                 seed;
  logic [`XLEN-1:0]       model_regs [0:`REG_COUNT-1];
  logic [ENTRY_W-1:0]     exp_q [$];
  logic [`XLEN-1:0]       prog [$];
  logic [ENTRY_W-1:0]     expected;
  int                     idx;
  int                     cycles;
  int                     cycle_limit;
  int                     drain;
  int                     value_errors;
  int                     protocol_errors;
  int                     timeout_errors;
  logic                   accepted;
  logic                   held;
  logic [`REG_ADDR_W-1:0] held_reg;
  logic [`XLEN-1:0]       held_data;
  logic                   done;

  tb_clock clock_i (
    .clock   (clock),
    .o_rst_n (rst_n)
  );

  core_top dut_i (
    .clock        (clock),
    .i_rst_n      (rst_n),
    .i_inst_valid (inst_valid),
    .i_inst       (inst_word),
    .o_inst_ready (inst_ready),
    .o_rpt_valid  (rpt_valid),
    .o_rpt_reg    (rpt_reg),
    .o_rpt_data   (rpt_data),
    .i_rpt_ready  (rpt_ready)
  );

  function automatic int random_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // Mostly x0..x17 so that reads hit recent writes
  function automatic logic [4:0] pick_reg();
    if (random_below(10) < 8) begin
      return 5'(random_below(18));
    end
    return 5'(random_below(32));
  endfunction

  function automatic logic [31:0] encode_reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] encode_imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] random_inst();
    int         kind;
    logic [2:0] f3;
    logic [6:0] opc;
    logic [11:0] imm;
    logic [31:0] w;
    kind = random_below(100);
    f3   = 3'(random_below(8));
    // ADD stands in for the unsigned compare this core lacks
    if (f3 == 3'b011) begin
      f3 = F3_ADD_SUB;
    end
    if (kind < 15) begin
      opc = 7'(random_below(128));
      while (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI) begin
        opc = 7'(random_below(128));
      end
      w = $random(seed);
      w[6:0] = opc;
      return w;
    end else if (kind < 45) begin
      if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && random_below(2) == 1) begin
        return encode_reg_op(ALT7, pick_reg(), pick_reg(), f3, pick_reg());
      end
      return encode_reg_op(7'd0, pick_reg(), pick_reg(), f3, pick_reg());
    end else if (kind < 77) begin
      imm = 12'($random(seed));
      // Shift immediates carry only the amount and the arithmetic bit
      if (f3 == F3_SLL) begin
        imm = {7'd0, 5'(random_below(32))};
      end else if (f3 == F3_SRL_SRA) begin
        imm = {1'b0, 1'(random_below(2)), 5'd0, 5'(random_below(32))};
      end
      return encode_imm_op(imm, pick_reg(), f3, pick_reg());
    end
    return encode_lui(20'($random(seed)), pick_reg());
  endfunction

  // Architectural effect of one instruction by the ISA rules
  task automatic apply_model(input logic [`XLEN-1:0] w);
    logic [6:0]       opc;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [2:0]       f3;
    logic             alt;
    logic             ok;
    logic [4:0]       sh;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    opc = w[6:0];
    rd  = w[11:7];
    f3  = w[14:12];
    rs1 = w[19:15];
    rs2 = w[24:20];
    alt = w[30];
    a   = model_regs[rs1];
    b   = (opc == OPC_OP) ? model_regs[rs2] : {{(`XLEN-12){w[31]}}, w[31:20]};
    sh  = b[4:0];
    ok  = 1'b1;
    res = '0;
    if (opc == OPC_LUI) begin
      res = {w[31:12], 12'd0};
    end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
      case (f3)
        F3_ADD_SUB: res = (opc == OPC_OP && alt) ? a - b : a + b;
        F3_SLL:     res = a << sh;
        F3_SLT:     res = ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
        F3_XOR:     res = a ^ b;
        F3_OR:      res = a | b;
        F3_AND:     res = a & b;
        F3_SRL_SRA: begin
          if (alt) begin
            res = $signed(a) >>> sh;
          end else begin
            res = a >> sh;
          end
        end
        default:    ok = 1'b0;
      endcase
    end else begin
      ok = 1'b0;
    end
    if (ok && rd != 5'd0) begin
      model_regs[rd] = res;
      if (int'(rd) >= `RPT_REG_LO && int'(rd) <= `RPT_REG_HI) begin
        exp_q.push_back({rd, res});
      end
    end
  endtask

  task automatic add_inst(input logic [`XLEN-1:0] w);
    prog.push_back(w);
    apply_model(w);
  endtask

  task automatic build_program();
    // Every register reads zero after reset
    for (int r = 0; r < `REG_COUNT; r++) begin
      add_inst(encode_imm_op(12'd0, 5'(r), F3_ADD_SUB, 5'(`RPT_REG_LO + r % 8)));
    end
    // Back-to-back dependencies through execute and writeback bypass
    add_inst(encode_lui(20'h80000, 5'd10));
    add_inst(encode_imm_op(12'hffb, 5'd0, F3_ADD_SUB, 5'd11));
    add_inst(encode_imm_op(12'h007, 5'd0, F3_ADD_SUB, 5'd12));
    add_inst(encode_reg_op(ALT7, 5'd11, 5'd12, F3_ADD_SUB, 5'd13));
    add_inst(encode_reg_op(ALT7, 5'd12, 5'd10, F3_SRL_SRA, 5'd14));
    add_inst(encode_reg_op(7'd0, 5'd12, 5'd11, F3_SLT, 5'd15));
    add_inst(encode_reg_op(7'd0, 5'd11, 5'd12, F3_SLT, 5'd16));
    add_inst(encode_reg_op(ALT7, 5'd13, 5'd15, F3_ADD_SUB, 5'd17));
    add_inst(encode_reg_op(7'd0, 5'd17, 5'd17, F3_ADD_SUB, 5'd10));
    add_inst(encode_reg_op(7'd0, 5'd12, 5'd10, F3_SRL_SRA, 5'd11));
    for (int n = 0; n < N_RANDOM; n++) begin
      add_inst(random_inst());
    end
    // Writes aimed at x0 and a read of x0 afterwards
    add_inst(encode_imm_op(12'h123, 5'd5, F3_ADD_SUB, 5'd0));
    add_inst(encode_reg_op(ALT7, 5'd12, 5'd13, F3_ADD_SUB, 5'd0));
    add_inst(encode_lui(20'hfffff, 5'd0));
    add_inst(encode_imm_op(12'd0, 5'd0, F3_ADD_SUB, 5'd10));
    add_inst(encode_reg_op(7'd0, 5'd0, 5'd0, F3_ADD_SUB, 5'd11));
  endtask

  initial begin
    seed            = 51574;
    inst_valid      = 1'b0;
    inst_word       = '0;
    rpt_ready       = 1'b0;
    idx             = 0;
    cycles          = 0;
    drain           = 0;
    value_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    held            = 1'b0;
    held_reg        = '0;
    held_data       = '0;
    done            = 1'b0;
    for (int r = 0; r < `REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
    build_program();
    cycle_limit = prog.size() * 12;

    wait (rst_n === 1'b1);
    assert (!rpt_valid) else begin
      $display("Report valid is high right after reset");
      protocol_errors++;
    end

    while (!done) begin
      @(posedge clock);
      cycles++;
      accepted = inst_valid && inst_ready;
      if (accepted) begin
        idx++;
      end
      // A waiting message must not move
      if (held) begin
        assert (rpt_valid) else begin
          $display("Report valid dropped before the message was taken");
          protocol_errors++;
        end
        assert (rpt_reg == held_reg) else begin
          $display("Fail o_rpt_reg expected %h got %h", held_reg, rpt_reg);
          value_errors++;
        end
        assert (rpt_data == held_data) else begin
          $display("Fail o_rpt_data expected %h got %h", held_data, rpt_data);
          value_errors++;
        end
      end
      held      = rpt_valid && !rpt_ready;
      held_reg  = rpt_reg;
      held_data = rpt_data;
      if (rpt_valid && rpt_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("Unexpected report for register %h with no write pending", rpt_reg);
          protocol_errors++;
        end
        if (exp_q.size() != 0) begin
          expected = exp_q.pop_front();
          assert (rpt_reg == expected[ENTRY_W-1:`XLEN]) else begin
            $display("Fail o_rpt_reg expected %h got %h", expected[ENTRY_W-1:`XLEN], rpt_reg);
            value_errors++;
          end
          assert (rpt_data == expected[`XLEN-1:0]) else begin
            $display("Fail o_rpt_data expected %h got %h", expected[`XLEN-1:0], rpt_data);
            value_errors++;
          end
        end
      end
      if (idx == prog.size() && exp_q.size() == 0) begin
        drain++;
      end
      if (drain >= DRAIN_CYCLES) begin
        done = 1'b1;
      end else if (cycles >= cycle_limit) begin
        $display("Timeout after %0d cycles with %0d of %0d instructions sent",
                 cycles, idx, prog.size());
        timeout_errors++;
        done = 1'b1;
      end

      #2;
      if (!inst_valid || accepted) begin
        if (idx < prog.size() && random_below(10) < 8) begin
          inst_valid = 1'b1;
          inst_word  = prog[idx];
        end else begin
          inst_valid = 1'b0;
        end
      end
      rpt_ready = (drain > 0) ? 1'b1 : (random_below(10) < 3);
    end

    assert (exp_q.size() == 0) else begin
      $display("%0d expected reports never arrived", exp_q.size());
      protocol_errors++;
    end
    $display("Errors: value %0d, protocol %0d, timeout %0d",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+design
design/isa_pkg.sv
design/alu_pkg.sv
design/inst_intake.sv
design/decode_regread.sv
design/alu_execute.sv
design/report_queue.sv
design/core_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f all.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "Test completed successfully" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
